//--- Makefile
TOOL     = verilator
TOP      = tb_render
FILELIST = sources.f
FLAGS    = --binary --timing --assert -Wno-fatal --top-module $(TOP)
OBJ_DIR  = obj_dir
LOG      = sim.log
FAIL_MSG = CHECKS FAILED

.PHONY: all compile run clean

all: run

compile:
	$(TOOL) $(FLAGS) --Mdir $(OBJ_DIR) -f $(FILELIST)

# failing exit status or the fail message in the log fails the run
run: compile
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; rc=$$?; cat $(LOG); \
	if [ $$rc -ne 0 ] || grep -q "$(FAIL_MSG)" $(LOG); then exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- hdl/render_pkg.sv
`default_nettype none

package render_pkg;

    // screen coordinate width
    localparam int COORD_W = 9;

    typedef logic [COORD_W-1:0] coord_t;

    // x in the upper half, y in the lower half
    typedef struct packed {
        coord_t x;
        coord_t y;
    } vertex_t;

    // index 0 is v1, 1 is v2, 2 is v3
    typedef vertex_t [2:0] tri_verts_t;

    // grey level, same value on all three channels
    typedef logic [7:0] shade_t;

    // holds a difference of two products of 10-bit signed terms
    typedef logic signed [2*COORD_W+1:0] edge_t;

    // 0 -> /1, 1 -> /2, 2 and 3 -> /4
    typedef logic [1:0] zoom_t;

    localparam shade_t FLAT_SHADE = 8'hCC;
    localparam shade_t BACKGROUND = 8'h00;

    // counter position to pixel pins
    localparam int RASTER_LATENCY = 2;

endpackage

`default_nettype wire

//--- hdl/render_top.sv
`timescale 1ns/1ps
`default_nettype none

module render_top #(
    parameter int H_ACTIVE = 1280,
    parameter int H_FRONT = 110,
    parameter int H_SYNC = 40,
    parameter int H_BACK = 220,
    parameter int V_ACTIVE = 720,
    parameter int V_FRONT = 5,
    parameter int V_SYNC = 5,
    parameter int V_BACK = 20
) (
    input wire clk_pixel,
    input wire rst_n,
    input wire tri_valid,
    input wire render_pkg::tri_verts_t tri_verts,
    input wire render_pkg::shade_t tri_shade,
    input wire obj_done,
    input wire render_pkg::zoom_t zoom,
    input wire flat_color,
    output logic tri_ready,
    output render_pkg::shade_t pixel,
    output logic hsync,
    output logic vsync,
    output logic de
);

    // raster position
    logic [render_pkg::COORD_W+1:0] hcount;
    logic [render_pkg::COORD_W+1:0] vcount;
    // unregistered timing, RASTER_LATENCY ahead of the pins
    logic hsync_raw;
    logic vsync_raw;
    logic active;
    logic frame_start;

    // displayed triangle, control to rasterizer
    tri_if scene ();

    video_timing #(
        .H_ACTIVE(H_ACTIVE),
        .H_FRONT(H_FRONT),
        .H_SYNC(H_SYNC),
        .H_BACK(H_BACK),
        .V_ACTIVE(V_ACTIVE),
        .V_FRONT(V_FRONT),
        .V_SYNC(V_SYNC),
        .V_BACK(V_BACK)
    ) u_timing (
        .clk_pixel(clk_pixel),
        .rst_n(rst_n),
        .hcount(hcount),
        .vcount(vcount),
        .hsync_raw(hsync_raw),
        .vsync_raw(vsync_raw),
        .active(active),
        .frame_start(frame_start)
    );

    scene_ctrl u_ctrl (
        .clk_pixel(clk_pixel),
        .rst_n(rst_n),
        .tri_valid(tri_valid),
        .tri_verts(tri_verts),
        .tri_shade(tri_shade),
        .obj_done(obj_done),
        .frame_start(frame_start),
        .tri_ready(tri_ready),
        .scene(scene.ctrl)
    );

    tri_raster u_raster (
        .clk_pixel(clk_pixel),
        .rst_n(rst_n),
        .hcount(hcount),
        .vcount(vcount),
        .hsync_raw(hsync_raw),
        .vsync_raw(vsync_raw),
        .active(active),
        .zoom(zoom),
        .flat_color(flat_color),
        .scene(scene.raster),
        .pixel(pixel),
        .hsync(hsync),
        .vsync(vsync),
        .de(de)
    );

endmodule

`default_nettype wire

//--- hdl/scene_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module scene_ctrl (
    input wire clk_pixel,
    input wire rst_n,
    input wire tri_valid,
    input wire render_pkg::tri_verts_t tri_verts,
    input wire render_pkg::shade_t tri_shade,
    input wire obj_done,
    input wire frame_start,
    output logic tri_ready,
    tri_if.ctrl scene
);

    typedef enum logic [1:0] {
        EMPTY,
        PENDING_TRI,
        PENDING_CLEAR
    } state_t;

    state_t state;
    state_t state_next;
    logic take;

    // triangle waiting for the next frame
    render_pkg::tri_verts_t pend_verts;
    render_pkg::shade_t pend_shade;

    // one slot, so ready only when nothing is queued
    assign tri_ready = (state == EMPTY);
    assign take = tri_valid && tri_ready;

    always_comb begin
        state_next = state;
        case (state)
            EMPTY: begin
                // a triangle wins over a simultaneous obj_done
                if (take) begin
                    state_next = PENDING_TRI;
                end else if (obj_done) begin
                    state_next = PENDING_CLEAR;
                end
            end
            PENDING_TRI, PENDING_CLEAR: begin
                if (frame_start) begin
                    state_next = EMPTY;
                end
            end
            default: state_next = EMPTY;
        endcase
    end

    always_ff @(posedge clk_pixel or negedge rst_n) begin
        if (!rst_n) begin
            state <= EMPTY;
        end else begin
            state <= state_next;
        end
    end

    always_ff @(posedge clk_pixel) begin
        if (take) begin
            pend_verts <= tri_verts;
            pend_shade <= tri_shade;
        end
    end

    // swap only at (0,0) so a frame never mixes two triangles
    always_ff @(posedge clk_pixel or negedge rst_n) begin
        if (!rst_n) begin
            scene.shown <= 1'b0;
            scene.verts <= '0;
            scene.shade <= '0;
            for (int i = 0; i < 3; i++) begin
                scene.pts[i][0] <= '0;
                scene.pts[i][1] <= '0;
            end
        end else if (frame_start && state == PENDING_TRI) begin
            scene.shown <= 1'b1;
            scene.verts <= pend_verts;
            scene.shade <= pend_shade;
            for (int i = 0; i < 3; i++) begin
                scene.pts[i][0] <= pend_verts[i].x;
                scene.pts[i][1] <= pend_verts[i].y;
            end
        end else if (frame_start && state == PENDING_CLEAR) begin
            // obj_done blanks the screen, old vertices just linger
            scene.shown <= 1'b0;
        end
    end

    // handshake stays closed from a take until the frame start that empties the slot
    assert property (@(posedge clk_pixel) disable iff (!rst_n)
        (take || (state != EMPTY && !frame_start)) |=> !tri_ready);

    // rasterizer sees a new picture only right after frame start
    assert property (@(posedge clk_pixel) disable iff (!rst_n)
        !$past(frame_start) |-> $stable({scene.verts, scene.shade, scene.shown}));

endmodule

`default_nettype wire

//--- hdl/tri_if.sv
`timescale 1ns/1ps
`default_nettype none

interface tri_if;

    // displayed triangle as it was handed over
    render_pkg::tri_verts_t verts;
    render_pkg::shade_t shade;
    // high while a triangle is on screen
    logic shown;
    // same vertices split out, pts[vertex][0] is x, pts[vertex][1] is y
    render_pkg::coord_t pts [3][2];

    // control side owns every field
    modport ctrl (output verts, output shade, output shown, output pts);

    // rasterizer only looks
    modport raster (input verts, input shade, input shown, input pts);

endinterface

`default_nettype wire

//--- hdl/tri_raster.sv
`timescale 1ns/1ps
`default_nettype none

module tri_raster (
    input wire clk_pixel,
    input wire rst_n,
    input wire [render_pkg::COORD_W+1:0] hcount,
    input wire [render_pkg::COORD_W+1:0] vcount,
    input wire hsync_raw,
    input wire vsync_raw,
    input wire active,
    input wire render_pkg::zoom_t zoom,
    input wire flat_color,
    tri_if.raster scene,
    output render_pkg::shade_t pixel,
    output logic hsync,
    output logic vsync,
    output logic de
);

    localparam int CW = render_pkg::COORD_W + 2;

    // (bx-ax)(py-ay) - (by-ay)(px-ax), sign tells the side of edge a->b
    function automatic render_pkg::edge_t edge_fn(
        input render_pkg::coord_t ax,
        input render_pkg::coord_t ay,
        input render_pkg::coord_t bx,
        input render_pkg::coord_t by,
        input render_pkg::coord_t px,
        input render_pkg::coord_t py
    );
        render_pkg::edge_t dx_ab;
        render_pkg::edge_t dy_ab;
        render_pkg::edge_t dx_ap;
        render_pkg::edge_t dy_ap;
        dx_ab = render_pkg::edge_t'(bx) - render_pkg::edge_t'(ax);
        dy_ab = render_pkg::edge_t'(by) - render_pkg::edge_t'(ay);
        dx_ap = render_pkg::edge_t'(px) - render_pkg::edge_t'(ax);
        dy_ap = render_pkg::edge_t'(py) - render_pkg::edge_t'(ay);
        return dx_ab * dy_ap - dy_ab * dx_ap;
    endfunction

    logic [1:0] shift;
    logic [CW-1:0] h_scaled;
    logic [CW-1:0] v_scaled;

    // stage one registers
    render_pkg::coord_t s1_px;
    render_pkg::coord_t s1_py;
    logic s1_in_range;
    logic s1_active;
    logic s1_hsync;
    logic s1_vsync;

    render_pkg::edge_t e12;
    render_pkg::edge_t e23;
    render_pkg::edge_t e31;
    logic all_pos;
    logic all_neg;
    logic covered;
    render_pkg::shade_t color;

    // zoom as a right shift, 3 behaves like 2
    always_comb begin
        case (zoom)
            2'd0: shift = 2'd0;
            2'd1: shift = 2'd1;
            default: shift = 2'd2;
        endcase
    end

    assign h_scaled = hcount >> shift;
    assign v_scaled = vcount >> shift;

    // stage one, scaled position plus timing
    always_ff @(posedge clk_pixel) begin
        s1_px <= h_scaled[render_pkg::COORD_W-1:0];
        s1_py <= v_scaled[render_pkg::COORD_W-1:0];
    end

    always_ff @(posedge clk_pixel or negedge rst_n) begin
        if (!rst_n) begin
            s1_in_range <= 1'b0;
            s1_active <= 1'b0;
            s1_hsync <= 1'b0;
            s1_vsync <= 1'b0;
        end else begin
            // past 511 the coordinate would wrap, treat as off-triangle
            s1_in_range <= (h_scaled[CW-1:render_pkg::COORD_W] == '0) &&
                           (v_scaled[CW-1:render_pkg::COORD_W] == '0);
            s1_active <= active;
            s1_hsync <= hsync_raw;
            s1_vsync <= vsync_raw;
        end
    end

    // edges evaluated against the triangle seen in stage two,
    // so pixel (0,0) already uses the one promoted at frame start
    assign e12 = edge_fn(scene.pts[0][0], scene.pts[0][1],
                         scene.pts[1][0], scene.pts[1][1], s1_px, s1_py);
    assign e23 = edge_fn(scene.pts[1][0], scene.pts[1][1],
                         scene.pts[2][0], scene.pts[2][1], s1_px, s1_py);
    assign e31 = edge_fn(scene.pts[2][0], scene.pts[2][1],
                         scene.pts[0][0], scene.pts[0][1], s1_px, s1_py);

    // same sign on all three edges, either winding
    assign all_pos = (e12 >= 0) && (e23 >= 0) && (e31 >= 0);
    assign all_neg = (e12 <= 0) && (e23 <= 0) && (e31 <= 0);
    assign covered = scene.shown && s1_active && s1_in_range && (all_pos || all_neg);

    assign color = flat_color ? render_pkg::FLAT_SHADE : scene.shade;

    // stage two, output pins
    always_ff @(posedge clk_pixel or negedge rst_n) begin
        if (!rst_n) begin
            pixel <= render_pkg::BACKGROUND;
            hsync <= 1'b0;
            vsync <= 1'b0;
            de <= 1'b0;
        end else begin
            pixel <= covered ? color : render_pkg::BACKGROUND;
            hsync <= s1_hsync;
            vsync <= s1_vsync;
            de <= s1_active;
        end
    end

    // blanking always black
    assert property (@(posedge clk_pixel) disable iff (!rst_n)
        !de |-> pixel == render_pkg::BACKGROUND);

endmodule

`default_nettype wire

//--- hdl/video_timing.sv
`timescale 1ns/1ps
`default_nettype none

module video_timing #(
    parameter int H_ACTIVE = 1280,
    parameter int H_FRONT = 110,
    parameter int H_SYNC = 40,
    parameter int H_BACK = 220,
    parameter int V_ACTIVE = 720,
    parameter int V_FRONT = 5,
    parameter int V_SYNC = 5,
    parameter int V_BACK = 20
) (
    input wire clk_pixel,
    input wire rst_n,
    output logic [render_pkg::COORD_W+1:0] hcount,
    output logic [render_pkg::COORD_W+1:0] vcount,
    output logic hsync_raw,
    output logic vsync_raw,
    output logic active,
    output logic frame_start
);

    // counter width, two bits above a screen coordinate
    localparam int CW = render_pkg::COORD_W + 2;

    localparam int H_TOTAL = H_ACTIVE + H_FRONT + H_SYNC + H_BACK;
    localparam int V_TOTAL = V_ACTIVE + V_FRONT + V_SYNC + V_BACK;

    // sync windows sit after the front porch
    localparam int H_SYNC_ON = H_ACTIVE + H_FRONT;
    localparam int H_SYNC_OFF = H_SYNC_ON + H_SYNC;
    localparam int V_SYNC_ON = V_ACTIVE + V_FRONT;
    localparam int V_SYNC_OFF = V_SYNC_ON + V_SYNC;

    logic line_end;
    logic frame_end;

    assign line_end = (hcount == CW'(H_TOTAL - 1));
    assign frame_end = (vcount == CW'(V_TOTAL - 1));

    // one pixel per clock, line counter steps at end of line
    always_ff @(posedge clk_pixel or negedge rst_n) begin
        if (!rst_n) begin
            hcount <= '0;
            vcount <= '0;
        end else if (line_end) begin
            hcount <= '0;
            vcount <= frame_end ? '0 : vcount + 1'b1;
        end else begin
            hcount <= hcount + 1'b1;
        end
    end

    // decoded straight from the counters so they stay aligned
    assign hsync_raw = (hcount >= CW'(H_SYNC_ON)) && (hcount < CW'(H_SYNC_OFF));
    // vsync spans whole lines
    assign vsync_raw = (vcount >= CW'(V_SYNC_ON)) && (vcount < CW'(V_SYNC_OFF));
    assign active = (hcount < CW'(H_ACTIVE)) && (vcount < CW'(V_ACTIVE));

    // counters sit at (0,0) for exactly one clock per frame
    assign frame_start = (hcount == '0) && (vcount == '0);

    // porches must keep the sync windows out of the picture
    assert property (@(posedge clk_pixel) disable iff (!rst_n)
        !(active && (hsync_raw || vsync_raw)));

endmodule

`default_nettype wire

//--- sources.f
hdl/render_pkg.sv
hdl/tri_if.sv
hdl/video_timing.sv
hdl/scene_ctrl.sv
hdl/tri_raster.sv
hdl/render_top.sv
verification/tb_render.sv

//--- verification/tb_render.sv
`timescale 1ns/1ps
`default_nettype none

module tb_render;

    // small frame, 48 cycles per line, 34 lines
    localparam int H_ACTIVE = 40;
    localparam int H_FRONT = 2;
    localparam int H_SYNC = 4;
    localparam int H_BACK = 2;
    localparam int V_ACTIVE = 30;
    localparam int V_FRONT = 1;
    localparam int V_SYNC = 2;
    localparam int V_BACK = 1;
    localparam int LINE_CYCLES = H_ACTIVE + H_FRONT + H_SYNC + H_BACK;
    localparam int FRAME_CYCLES = LINE_CYCLES * (V_ACTIVE + V_FRONT + V_SYNC + V_BACK);
    // hsync window follows the front porch
    localparam int H_SYNC_ON = H_ACTIVE + H_FRONT;
    // tests need about 15 frames
    localparam int TIMEOUT_CYCLES = 20 * FRAME_CYCLES;
    localparam int SEED = 52963;

    logic clk = 1'b0;
    logic rst_n;
    logic tri_valid;
    render_pkg::tri_verts_t tri_verts;
    render_pkg::shade_t tri_shade;
    logic obj_done;
    render_pkg::zoom_t zoom;
    logic flat_color;
    logic tri_ready;
    render_pkg::shade_t pixel;
    logic hsync;
    logic vsync;
    logic de;

    // scene model, pend_kind 0 none, 1 triangle, 2 clear
    int pend_kind = 0;
    render_pkg::tri_verts_t pend_verts;
    render_pkg::shade_t pend_shade;
    render_pkg::tri_verts_t disp_verts;
    render_pkg::shade_t disp_shade;
    bit disp_shown = 1'b0;

    // position tracking from the output pins
    int row = 0;
    int col = 0;
    bit de_q = 1'b0;
    bit vsync_q = 1'b0;
    int frames = 0;
    int last_take_frame = 0;
    // cycle within the line, zero on rising de
    int hpos = 0;
    bit line_locked = 1'b0;
    int vsync_len = 0;

    int checks = 0;
    int errors = 0;
    int test_checks = 0;
    int test_errors = 0;
    int cycles = 0;

    render_top #(
        .H_ACTIVE(H_ACTIVE),
        .H_FRONT(H_FRONT),
        .H_SYNC(H_SYNC),
        .H_BACK(H_BACK),
        .V_ACTIVE(V_ACTIVE),
        .V_FRONT(V_FRONT),
        .V_SYNC(V_SYNC),
        .V_BACK(V_BACK)
    ) DUT (
        .clk_pixel(clk),
        .rst_n(rst_n),
        .tri_valid(tri_valid),
        .tri_verts(tri_verts),
        .tri_shade(tri_shade),
        .obj_done(obj_done),
        .zoom(zoom),
        .flat_color(flat_color),
        .tri_ready(tri_ready),
        .pixel(pixel),
        .hsync(hsync),
        .vsync(vsync),
        .de(de)
    );

    always #4 clk = ~clk;

    // expected grey for one screen pixel, edges v1->v2, v2->v3, v3->v1
    function automatic render_pkg::shade_t expected_pixel(
        input render_pkg::tri_verts_t v,
        input render_pkg::shade_t s,
        input bit shown,
        input render_pkg::zoom_t z,
        input bit flat,
        input int x,
        input int y
    );
        int scale;
        int px;
        int py;
        int e;
        int j;
        bit pos;
        bit neg;
        scale = (z == 0) ? 1 : ((z == 1) ? 2 : 4);
        px = x / scale;
        py = y / scale;
        pos = 1'b1;
        neg = 1'b1;
        for (int i = 0; i < 3; i++) begin
            j = (i + 1) % 3;
            e = (int'(v[j].x) - int'(v[i].x)) * (py - int'(v[i].y)) -
                (int'(v[j].y) - int'(v[i].y)) * (px - int'(v[i].x));
            if (e < 0) pos = 1'b0;
            if (e > 0) neg = 1'b0;
        end
        if (!shown || !(pos || neg)) begin
            return render_pkg::BACKGROUND;
        end
        return flat ? render_pkg::FLAT_SHADE : s;
    endfunction

    function automatic render_pkg::tri_verts_t make_tri(
        input int x1, input int y1, input int x2, input int y2, input int x3, input int y3
    );
        render_pkg::tri_verts_t v;
        v[0].x = render_pkg::coord_t'(x1);
        v[0].y = render_pkg::coord_t'(y1);
        v[1].x = render_pkg::coord_t'(x2);
        v[1].y = render_pkg::coord_t'(y2);
        v[2].x = render_pkg::coord_t'(x3);
        v[2].y = render_pkg::coord_t'(y3);
        return v;
    endfunction

    function automatic render_pkg::tri_verts_t rand_tri(input int span);
        return make_tri($urandom % span, $urandom % span, $urandom % span,
                        $urandom % span, $urandom % span, $urandom % span);
    endfunction

    task automatic check_value(input string name, input int exp, input int got);
        checks++;
        assert (got == exp) else begin
            $display("ERR %0t %s expected %0h got %0h", $time, name, exp, got);
            errors++;
        end
    endtask

    task automatic report_test(input string name);
        $display("%s: %0d checks, %0d errors", name, checks - test_checks,
                 errors - test_errors);
        test_checks = checks;
        test_errors = errors;
    endtask

    // rising vsync, then the next falling edge
    task automatic wait_mark();
        @(posedge vsync);
        @(negedge clk);
    endtask

    task automatic send_tri(input render_pkg::tri_verts_t v, input render_pkg::shade_t s);
        // start inside the picture, so the take lands between two vsyncs
        do @(negedge clk); while (!de);
        tri_valid = 1'b1;
        tri_verts = v;
        tri_shade = s;
        // hold data under back-pressure
        while (!tri_ready) @(negedge clk);
        pend_kind = 1;
        pend_verts = v;
        pend_shade = s;
        last_take_frame = frames;
        @(negedge clk);
        tri_valid = 1'b0;
        check_value("tri_ready", 0, tri_ready);
    endtask

    task automatic clear_scene();
        do @(negedge clk); while (!de);
        obj_done = 1'b1;
        check_value("tri_ready", 1, tri_ready);
        pend_kind = 2;
        @(negedge clk);
        obj_done = 1'b0;
    endtask

    // tracker, model update and pixel compare, all on stable outputs
    always @(negedge clk) begin
        if (rst_n) begin
            if (vsync && !vsync_q) begin
                check_value("rows", V_ACTIVE, row);
                frames++;
                row = 0;
                col = 0;
                if (pend_kind == 1) begin
                    disp_verts = pend_verts;
                    disp_shade = pend_shade;
                    disp_shown = 1'b1;
                end else if (pend_kind == 2) begin
                    disp_shown = 1'b0;
                end
                pend_kind = 0;
            end
            if (de) begin
                check_value("pixel", expected_pixel(disp_verts, disp_shade, disp_shown,
                            zoom, flat_color, col, row), pixel);
                col++;
            end else if (de_q) begin
                check_value("columns", H_ACTIVE, col);
                row++;
                col = 0;
            end
            // line phase restarts on every rising de
            if (de && !de_q) begin
                hpos = 0;
                line_locked = 1'b1;
            end else begin
                hpos = (hpos + 1) % LINE_CYCLES;
            end
            if (line_locked) begin
                check_value("hsync", (hpos >= H_SYNC_ON) && (hpos < H_SYNC_ON + H_SYNC),
                            hsync);
            end
            // vsync spans whole lines
            if (vsync) begin
                vsync_len++;
            end else if (vsync_q) begin
                check_value("vsync length", V_SYNC * LINE_CYCLES, vsync_len);
                vsync_len = 0;
            end
            de_q = de;
            vsync_q = vsync;
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles >= TIMEOUT_CYCLES) begin
            $display("run timed out after %0d cycles, tests did not finish", cycles);
            $display("CHECKS FAILED");
            $finish;
        end
    end

    initial begin
        int first_frame;
        void'($urandom(SEED));
        rst_n = 1'b0;
        tri_valid = 1'b0;
        tri_verts = '0;
        tri_shade = '0;
        obj_done = 1'b0;
        zoom = '0;
        flat_color = 1'b0;
        repeat (5) @(posedge clk);
        @(negedge clk);
        check_value("tri_ready", 1, tri_ready);
        check_value("de", 0, de);
        check_value("pixel", 0, pixel);
        rst_n = 1'b1;

        // counters leave (0,0) on release, first de follows after the pipeline
        repeat (render_pkg::RASTER_LATENCY - 1) @(negedge clk);
        check_value("de", 0, de);
        @(negedge clk);
        check_value("de", 1, de);

        // empty frame is all background
        wait_mark();
        report_test("test 1 reset and empty frame");

        // both windings, then three points on one line
        send_tri(make_tri(4, 3, 30, 8, 12, 25), 8'h5A);
        wait_mark();
        send_tri(make_tri(4, 3, 12, 25, 30, 8), 8'hA5);
        wait_mark();
        send_tri(make_tri(2, 2, 10, 10, 20, 20), 8'h77);
        wait_mark();
        wait_mark();
        report_test("test 2 triangle display");

        // second triangle waits for the slot to empty
        send_tri(make_tri(0, 0, 39, 0, 20, 29), 8'h33);
        first_frame = last_take_frame;
        send_tri(make_tri(5, 28, 35, 28, 20, 1), 8'hE1);
        check_value("take frame", first_frame + 1, last_take_frame);
        wait_mark();
        wait_mark();
        report_test("test 3 back-pressure");

        // zoom changes only in vertical blanking
        send_tri(rand_tri(48), render_pkg::shade_t'(1 + $urandom % 255));
        for (int z = 0; z < 3; z++) begin
            wait_mark();
            zoom = render_pkg::zoom_t'(z);
            send_tri(rand_tri(48 >> z), render_pkg::shade_t'(1 + $urandom % 255));
        end
        wait_mark();
        report_test("test 4 zoom");

        flat_color = 1'b1;
        wait_mark();
        flat_color = 1'b0;
        zoom = '0;
        report_test("test 5 flat colour");

        // still shown this frame, blank in the next
        clear_scene();
        wait_mark();
        wait_mark();
        report_test("test 6 object done");

        $display("%0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire
